/* flist.f */
+incdir+.
fe_pkg.sv
if_id_reg.sv
inst_reserve_stack.sv
pre_decode.sv
frontend_top.sv
tb_frontend.sv

/* run.sh */
#!/bin/sh
# compile and run the front-end testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_frontend \
    -f flist.f -o sim_frontend
./obj_dir/sim_frontend > sim.log 2>&1 || true
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
# a run that ends without a verdict also fails
grep -q "NO ERRORS" sim.log

/* tb_frontend.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fe_defines.svh"

// testbench for the front-end hand-off
// plays fetch and decode, every packet that reaches decode is checked in order
module tb_frontend;

    localparam int DEPTH       = `FE_RS_DEPTH;
    localparam int DRAIN_LIMIT = 60;
    // opcodes for random words, last one falls in the other class
    localparam logic [6:0] OPS [8] = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h37};

    // one stimulus row
    typedef struct {
        string              name;
        fe_pkg::fetch_pkt_t pkt;
        logic               stall;
        logic               flush;
        // latency of this packet must be two edges
        logic               timed;
    } row_t;

    // packet owed to decode, tagged with its accept cycle
    typedef struct packed {
        fe_pkg::fetch_pkt_t pkt;
        logic [31:0]        step_no;
        logic               timed;
    } exp_entry_t;

    logic               clk;
    logic               rst_n;
    fe_pkg::fetch_pkt_t fetch_pkt_i;
    logic               flush_i;
    logic               dec_stall_i;
    logic               fe_stall_o;
    logic               dec_valid_o;
    fe_pkg::dec_pkt_t   dec_pkt_o;

    row_t        rows[$];
    exp_entry_t  exp_q[$];
    string       cur_test;
    logic [31:0] lfsr = 32'hf92cda33;
    logic [31:0] cyc = '0;
    // expected state of IF/ID, stack and pre-decode valid
    int          occ = 0;
    logic        ifid_v = 1'b0;
    logic        exp_valid = 1'b0;
    logic        timed_out = 1'b0;
    int          n_tests = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          test_pkts = 0;
    int          test_errors = 0;

    frontend_top frontend_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_pkt_i (fetch_pkt_i),
        .flush_i     (flush_i),
        .dec_stall_i (dec_stall_i),
        .fe_stall_o  (fe_stall_o),
        .dec_valid_o (dec_valid_o),
        .dec_pkt_o   (dec_pkt_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < nbits; b++) begin
            val  = {val[30:0], lfsr[31]};
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        end
        return val;
    endfunction

    // RV32I major opcode to class
    function automatic fe_pkg::inst_class_e opcode_class(input logic [6:0] op);
        case (op)
            7'h33, 7'h13: return fe_pkg::CLS_ALU;
            7'h03:        return fe_pkg::CLS_LOAD;
            7'h23:        return fe_pkg::CLS_STORE;
            7'h63:        return fe_pkg::CLS_BRANCH;
            7'h6f:        return fe_pkg::CLS_JAL;
            7'h67:        return fe_pkg::CLS_JALR;
            default:      return fe_pkg::CLS_OTHER;
        endcase
    endfunction

    function automatic void add_row(input string name, input logic [31:0] inst,
                                    input logic [31:0] addr, input logic pred,
                                    input logic valid, input logic stall,
                                    input logic flush, input logic timed);
        row_t r;
        r.name  = name;
        r.pkt   = '{inst: inst, inst_addr: addr, is_pred_branch: pred, inst_valid: valid};
        r.stall = stall;
        r.flush = flush;
        r.timed = timed;
        rows.push_back(r);
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
        n_checks++;
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            n_errors++;
            test_errors++;
        end
    endtask

    // drive on the falling edge, sample halfway to the rising edge
    task automatic run_cycle(input fe_pkg::fetch_pkt_t pkt, input logic stall,
                             input logic flush, input logic timed);
        exp_entry_t          head;
        exp_entry_t          ent;
        fe_pkg::inst_class_e cls;
        logic                ctrl;
        logic                old_full;
        logic                push;
        logic                pop;
        @(negedge clk);
        fetch_pkt_i = pkt;
        dec_stall_i = stall;
        flush_i     = flush;
        #25;
        check_val("dec_valid_o", 64'(exp_valid), 64'(dec_valid_o));
        check_val("fe_stall_o", 64'(occ == DEPTH), 64'(fe_stall_o));
        // decode takes the packet on this edge
        if (dec_valid_o && !stall) begin
            if (exp_q.size() == 0) begin
                $display("test %s: decode got a packet that fetch never sent", cur_test);
                n_errors++;
                test_errors++;
            end else begin
                head = exp_q.pop_front();
                cls  = opcode_class(head.pkt.inst[6:0]);
                ctrl = cls inside {fe_pkg::CLS_BRANCH, fe_pkg::CLS_JAL, fe_pkg::CLS_JALR};
                check_val("inst", 64'(head.pkt.inst), 64'(dec_pkt_o.inst));
                check_val("inst_addr", 64'(head.pkt.inst_addr), 64'(dec_pkt_o.inst_addr));
                check_val("cls", 64'(cls), 64'(dec_pkt_o.cls));
                check_val("is_ctrl", 64'(ctrl), 64'(dec_pkt_o.is_ctrl));
                check_val("pred_mismatch", 64'(head.pkt.is_pred_branch && !ctrl),
                          64'(dec_pkt_o.pred_mismatch));
                check_val("is_pred_branch", 64'(head.pkt.is_pred_branch),
                          64'(dec_pkt_o.is_pred_branch));
                if (head.timed) begin
                    check_val("latency", 64'(2), 64'(cyc - head.step_no));
                end
                test_pkts++;
            end
        end
        // expected state after the coming edge
        old_full = (occ == DEPTH);
        if (flush) begin
            exp_q.delete();
            occ       = 0;
            ifid_v    = 1'b0;
            exp_valid = 1'b0;
        end else begin
            push = ifid_v && (stall || occ != 0) && !old_full;
            pop  = (occ != 0) && !stall;
            if (!stall) begin
                exp_valid = (occ != 0) || ifid_v;
            end
            occ = occ + int'(push) - int'(pop);
            // full stack holds IF/ID, fetch's word is not taken
            if (!old_full) begin
                ifid_v = pkt.inst_valid;
                if (pkt.inst_valid) begin
                    ent.pkt     = pkt;
                    ent.step_no = cyc;
                    ent.timed   = timed;
                    exp_q.push_back(ent);
                end
            end
        end
        cyc++;
    endtask

    // idle fetch with decode ready until all owed packets are out
    task automatic drain_test();
        fe_pkg::fetch_pkt_t idle;
        int                 waited;
        idle   = '0;
        waited = 0;
        while ((exp_q.size() != 0 || waited < 3) && waited < DRAIN_LIMIT) begin
            run_cycle(idle, 1'b0, 1'b0, 1'b0);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in test %s: %0d packets never reached decode",
                     cur_test, exp_q.size());
            timed_out = 1'b1;
            n_errors++;
        end
        $display("test %s done: %0d packets out, %0d errors", cur_test, test_pkts, test_errors);
        n_tests++;
        test_pkts   = 0;
        test_errors = 0;
    endtask

    initial begin
        fe_pkg::fetch_pkt_t rpkt;
        logic [31:0]        word;
        logic [3:0]         ctl;
        rst_n       = 1'b0;
        fetch_pkt_i = '0;
        flush_i     = 1'b0;
        dec_stall_i = 1'b0;
        // name, inst, addr, pred, valid, stall, flush, timed
        add_row("opcode", 32'h003100b3, 32'h100, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("opcode", 32'h00a08093, 32'h104, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("opcode", 32'h0040a103, 32'h108, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("opcode", 32'h0020a223, 32'h10c, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("opcode", 32'h00208463, 32'h110, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("opcode", 32'h008000ef, 32'h114, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("opcode", 32'h000080e7, 32'h118, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("opcode", 32'h123450b7, 32'h11c, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("pred", 32'h003100b3, 32'h120, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("pred", 32'h0040a103, 32'h124, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("pred", 32'h0020a223, 32'h128, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("pred", 32'h00208463, 32'h12c, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("pred", 32'h008000ef, 32'h130, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row("pred", 32'h000080e7, 32'h134, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        // stall past depth, fetch stall must rise and words beyond it are not taken
        add_row("fill", 32'h00a08093, 32'h200, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        add_row("fill", 32'h0040a103, 32'h204, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        add_row("fill", 32'h0020a223, 32'h208, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        add_row("fill", 32'h00208463, 32'h20c, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        add_row("fill", 32'h003100b3, 32'h210, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        add_row("fill", 32'h008000ef, 32'h214, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        add_row("fill", 32'h000080e7, 32'h218, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        add_row("fill", 32'h123450b7, 32'h21c, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        // flush with a full stack and a valid word held in pre-decode
        // only later words may reach decode
        add_row("flush", 32'h003100b3, 32'h300, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        add_row("flush", 32'h00a08093, 32'h304, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        add_row("flush", 32'h0040a103, 32'h308, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        add_row("flush", 32'h0020a223, 32'h30c, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        add_row("flush", 32'h00208463, 32'h310, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        add_row("flush", 32'h00c000ef, 32'h314, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        add_row("flush", 32'h008000ef, 32'h318, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
        add_row("flush", 32'h000080e7, 32'h400, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        add_row("flush", 32'h123450b7, 32'h404, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        cur_test = rows[0].name;
        foreach (rows[i]) begin
            if (rows[i].name != cur_test) begin
                drain_test();
                cur_test = rows[i].name;
            end
            if (timed_out) begin
                break;
            end
            run_cycle(rows[i].pkt, rows[i].stall, rows[i].flush, rows[i].timed);
        end
        if (!timed_out) begin
            drain_test();
        end
        // random stalls and bubbles
        if (!timed_out) begin
            cur_test = "random";
            for (int n = 0; n < 300; n++) begin
                word = lfsr_take(32);
                ctl  = 4'(lfsr_take(4));
                rpkt.inst           = {word[31:7], OPS[word[2:0]]};
                rpkt.inst_addr      = 32'h800 + 32'(4 * n);
                rpkt.is_pred_branch = ctl[0];
                rpkt.inst_valid     = (ctl[2:1] != 2'b00);
                run_cycle(rpkt, ctl[3], 1'b0, 1'b0);
            end
            drain_test();
        end
        $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (timed_out || n_errors != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* frontend_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fe_defines.svh"

// front-end hand-off, fetch to start of decode
// IF/ID register, reserve stack, pre-decode in a straight line
module frontend_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire fe_pkg::fetch_pkt_t fetch_pkt_i,
    input  wire                     flush_i,
    // decode cannot take a packet this cycle
    input  wire                     dec_stall_i,
    // fetch must hold its packet
    output logic                    fe_stall_o,
    output logic                    dec_valid_o,
    output fe_pkg::dec_pkt_t        dec_pkt_o
);

    // IF/ID output
    fe_pkg::fetch_pkt_t id_pkt;
    // bypassed input or head of stack
    fe_pkg::fetch_pkt_t rs_pkt;

    // held while the stack is full
    if_id_reg if_id_reg_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (fe_stall_o),
        .flush_i (flush_i),
        .pkt_i   (fetch_pkt_i),
        .pkt_o   (id_pkt)
    );

    // decode stall both requests storage and blocks the pop
    inst_reserve_stack #(
        .DEPTH (`FE_RS_DEPTH)
    ) inst_reserve_stack_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_req_i   (dec_stall_i),
        .fifo_stall_i (dec_stall_i),
        .fifo_flush_i (flush_i),
        .fifo_full_o  (fe_stall_o),
        .pkt_i        (id_pkt),
        .pkt_o        (rs_pkt)
    );

    pre_decode pre_decode_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold_i      (dec_stall_i),
        .flush_i     (flush_i),
        .pkt_i       (rs_pkt),
        .dec_valid_o (dec_valid_o),
        .dec_pkt_o   (dec_pkt_o)
    );

endmodule

`default_nettype wire

/* pre_decode.sv */
`timescale 1ns/10ps
`default_nettype none

// pre-decode stage
// classifies by major opcode, checks the prediction flag, registers for decode
module pre_decode (
    input  wire                     clk,
    input  wire                     rst_n,
    // decode stall, output keeps its packet
    input  wire                     hold_i,
    input  wire                     flush_i,
    input  wire fe_pkg::fetch_pkt_t pkt_i,
    output logic                    dec_valid_o,
    output fe_pkg::dec_pkt_t        dec_pkt_o
);

    fe_pkg::inst_class_e cls;
    logic                is_ctrl;
    fe_pkg::dec_pkt_t    dec_nxt;

    // RV32I major opcode, bits 6:0
    always_comb begin
        case (pkt_i.inst[6:0])
            // OP and OP-IMM
            7'b0110011, 7'b0010011: cls = fe_pkg::CLS_ALU;
            7'b0000011:             cls = fe_pkg::CLS_LOAD;
            7'b0100011:             cls = fe_pkg::CLS_STORE;
            7'b1100011:             cls = fe_pkg::CLS_BRANCH;
            7'b1101111:             cls = fe_pkg::CLS_JAL;
            7'b1100111:             cls = fe_pkg::CLS_JALR;
            // lui, auipc, fence, system and illegal words
            default:                cls = fe_pkg::CLS_OTHER;
        endcase
    end

    assign is_ctrl = (cls == fe_pkg::CLS_BRANCH) ||
                     (cls == fe_pkg::CLS_JAL)    ||
                     (cls == fe_pkg::CLS_JALR);

    always_comb begin
        dec_nxt.inst           = pkt_i.inst;
        dec_nxt.inst_addr      = pkt_i.inst_addr;
        dec_nxt.cls            = cls;
        dec_nxt.is_ctrl        = is_ctrl;
        // predictor flagged a word that cannot redirect
        dec_nxt.pred_mismatch  = pkt_i.is_pred_branch && !is_ctrl;
        dec_nxt.is_pred_branch = pkt_i.is_pred_branch;
    end

    // flush wins over hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid_o <= 1'b0;
        end else if (flush_i) begin
            dec_valid_o <= 1'b0;
        end else if (!hold_i) begin
            dec_valid_o <= pkt_i.inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            dec_pkt_o <= dec_nxt;
        end
    end

    // valid to decode is always a known level once out of reset
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(dec_valid_o)
    ) else $error("dec_valid_o unknown after reset");

endmodule

`default_nettype wire

/* inst_reserve_stack.sv */
`timescale 1ns/10ps
`default_nettype none

// instruction reserve stack
// small FIFO between IF/ID and pre-decode
// empty: input goes straight through, no added latency
// decode stalled: packets collect here in fetch order
module inst_reserve_stack #(
    parameter int DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     rst_n,
    // decode stalled, start storing
    input  wire                     push_req_i,
    // decode stalled, do not hand out the head
    input  wire                     fifo_stall_i,
    input  wire                     fifo_flush_i,
    // back-pressure to fetch
    output logic                    fifo_full_o,
    input  wire fe_pkg::fetch_pkt_t pkt_i,
    output fe_pkg::fetch_pkt_t      pkt_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    // last slot before the pointers wrap
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    // storage, no reset
    fe_pkg::fetch_pkt_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_nxt;
    logic [PTR_W-1:0] rd_ptr_nxt;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             full;
    logic             push_en;
    logic             do_push;
    logic             pop_en;

    assign empty = (count == '0);
    assign full  = (count == FULL_CNT);

    // once anything is stored, every new valid packet queues behind it
    // otherwise it would overtake the stored ones through the bypass
    assign push_en = pkt_i.inst_valid && (push_req_i || !empty);
    // full: packet stays in IF/ID, which is held by fifo_full_o
    assign do_push = push_en && !full;
    assign pop_en  = !empty && !fifo_stall_i;

    // wrap by compare, depth need not be a power of two
    assign wr_ptr_nxt = (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
    assign rd_ptr_nxt = (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;

    // bypass when empty, head of queue otherwise
    assign pkt_o       = empty ? pkt_i : mem[rd_ptr];
    assign fifo_full_o = full;

    // pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (fifo_flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr_nxt;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr_nxt;
            end
            // push and pop together leave the count alone
            case ({do_push, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= pkt_i;
        end
    end

    // occupancy stays within the buffer
    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= FULL_CNT
    ) else $error("reserve stack count above depth");

    // a pop reads a slot that an earlier push filled
    // pointers only meet when the buffer is empty or full
    a_pop_written: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop_en |-> ((wr_ptr != rd_ptr) || full) && mem[rd_ptr].inst_valid
    ) else $error("reserve stack popped an empty slot");

endmodule

`default_nettype wire

/* if_id_reg.sv */
`timescale 1ns/10ps
`default_nettype none

// IF/ID pipeline register
// one cycle from fetch to the reserve stack
module if_id_reg (
    input  wire                     clk,
    input  wire                     rst_n,
    // reserve stack full, keep fetch's packet here
    input  wire                     hold_i,
    input  wire                     flush_i,
    input  wire fe_pkg::fetch_pkt_t pkt_i,
    output fe_pkg::fetch_pkt_t      pkt_o
);

    // valid is control, rest is payload
    logic                      valid_q;
    logic [$bits(pkt_i.inst)-1:0]      inst_q;
    logic [$bits(pkt_i.inst_addr)-1:0] addr_q;
    logic                      pred_q;

    // flush drops whatever is in flight as a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!hold_i) begin
            valid_q <= pkt_i.inst_valid;
        end
    end

    // payload follows the valid bit on the same enable
    always_ff @(posedge clk) begin
        if (!hold_i) begin
            inst_q <= pkt_i.inst;
            addr_q <= pkt_i.inst_addr;
            pred_q <= pkt_i.is_pred_branch;
        end
    end

    always_comb begin
        pkt_o.inst           = inst_q;
        pkt_o.inst_addr      = addr_q;
        pkt_o.is_pred_branch = pred_q;
        pkt_o.inst_valid     = valid_q;
    end

endmodule

`default_nettype wire

/* fe_pkg.sv */
`default_nettype none

`include "fe_defines.svh"

package fe_pkg;

    // one fetched instruction as it leaves the fetch stage
    typedef struct packed {
        logic [`FE_INST_WIDTH-1:0] inst;
        logic [`FE_ADDR_WIDTH-1:0] inst_addr;
        // branch predictor said taken for this word
        logic                      is_pred_branch;
        logic                      inst_valid;
    } fetch_pkt_t;

    // coarse class from the RV32I major opcode
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_OTHER
    } inst_class_e;

    // pre-decoded packet handed to decode
    typedef struct packed {
        logic [`FE_INST_WIDTH-1:0] inst;
        logic [`FE_ADDR_WIDTH-1:0] inst_addr;
        inst_class_e               cls;
        // branch, jal or jalr
        logic                      is_ctrl;
        // predicted taken but not a control transfer
        logic                      pred_mismatch;
        logic                      is_pred_branch;
    } dec_pkt_t;

endpackage

`default_nettype wire

/* fe_defines.svh */
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// front-end widths and sizes
// shared by the package and the top level

// instruction word width
// RV32I base, no compressed forms
`define FE_INST_WIDTH 32

// instruction address width
// byte address of the fetched word
`define FE_ADDR_WIDTH 32

// reserve stack depth in entries
// also the number of packets that decode can fall behind before fetch stalls
// keep at two or more, pointers need at least one bit
`define FE_RS_DEPTH 4

`endif
